//--- vlog.f
+incdir+source
source/cpu_types_pkg.sv
source/register_file.sv
source/alu.sv
source/control_unit.sv
source/hazard_unit.sv
source/forward_unit.sv
source/datapath.sv
dv/tb_clock_gen.sv
dv/datapath_asserts.sv
dv/datapath_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the pipeline testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module datapath_tb -o sim_datapath \
  && ./obj_dir/sim_datapath | tee /dev/stderr | grep -q "^Done: no errors$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- dv/datapath_tb.sv
/* memories answer with 0 to 3 wait states from an LFSR; expected stores are hand computed
   data memory holds 256 words, upper address bits are ignored */
`timescale 1ns/1ns
`default_nettype none

module datapath_tb
  import cpu_types_pkg::*;
;
  localparam int NUM_STORES = 12;
  localparam int NUM_LOADS  = 2;
  localparam int PROG_LEN   = 36;

  logic  clk, arst_n, imem_ren, ihit, dmem_ren, dmem_wen, dhit, halt;
  word_t imem_addr, imem_load, dmem_addr, dmem_store, dmem_load;
  word_t imem [256];
  word_t dmem [256];
  word_t prog [PROG_LEN];
  word_t exp_addr [NUM_STORES];
  word_t exp_data [NUM_STORES];
  word_t exp_load [NUM_LOADS];
  logic [31:0] lfsr_state = 32'hfa41;
  int    errors = 0;
  int    stores_seen = 0;
  int    loads_seen = 0;
  logic  i_pending = 1'b0;
  logic  d_pending = 1'b0;
  int    i_left, d_left;
  word_t i_addr_q, d_addr_q;

  tb_clock_gen u_clk (.CLK(clk), .arst_n(arst_n));

  datapath dut (
    .CLK(clk), .arst_n(arst_n), .imem_ren(imem_ren), .imem_addr(imem_addr),
    .imem_load(imem_load), .ihit(ihit), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
    .dmem_addr(dmem_addr), .dmem_store(dmem_store), .dmem_load(dmem_load), .dhit(dhit),
    .halt(halt)
  );

  bind datapath datapath_asserts u_asserts (.*);

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int val;
    val = 0;
    for (int k = 0; k < n; k++) begin
      val = (val << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    return val;
  endfunction

  function automatic word_t fill_word(input int idx);
    return 32'hc0de_0000 ^ (idx << 8) ^ idx;
  endfunction

  function automatic word_t enc_r(input logic [5:0] fn, input int rd, input int rs,
                                  input int rt);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic word_t enc_i(input logic [5:0] op, input int rt, input int rs,
                                  input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction

  task automatic load_tables();
    prog[0]  = enc_i(ADDIU, 1, 0, 16'h0005);
    prog[1]  = enc_i(ADDIU, 2, 0, 16'hfffd);
    prog[2]  = enc_r(ADDU, 3, 1, 2);
    prog[3]  = enc_i(SW, 3, 0, 16'h0000);
    prog[4]  = enc_r(SUBU, 4, 1, 2);
    prog[5]  = enc_i(SW, 4, 0, 16'h0004);
    prog[6]  = enc_i(ORI, 6, 1, 16'h00f2);
    prog[7]  = enc_r(AND, 5, 6, 2);
    prog[8]  = enc_r(OR, 7, 5, 4);
    prog[9]  = enc_i(SW, 7, 0, 16'h0008);
    prog[10] = enc_i(SW, 5, 0, 16'h000c);
    prog[11] = enc_r(SLT, 8, 2, 1);
    prog[12] = enc_r(SLT, 9, 1, 2);
    prog[13] = enc_i(LUI, 10, 0, 16'h1234);
    prog[14] = enc_i(ORI, 10, 10, 16'h5678);
    prog[15] = enc_i(SW, 8, 0, 16'h0010);
    prog[16] = enc_i(SW, 10, 0, 16'h0014);
    prog[17] = enc_i(SW, 9, 0, 16'h0018);
    // load-use pairs, on an ALU operand and on store data
    prog[18] = enc_i(LW, 12, 0, 16'h0040);
    prog[19] = enc_r(ADDU, 13, 12, 1);
    prog[20] = enc_i(SW, 13, 0, 16'h001c);
    prog[21] = enc_i(LW, 14, 0, 16'h0014);
    prog[22] = enc_i(SW, 14, 0, 16'h0020);
    prog[23] = enc_i(BEQ, 2, 1, 16'h0002);
    prog[24] = enc_i(SW, 1, 0, 16'h0024);
    // taken, lands on 29
    prog[25] = enc_i(BEQ, 3, 3, 16'h0003);
    prog[26] = enc_i(SW, 1, 0, 16'h0028);
    prog[27] = enc_i(SW, 2, 0, 16'h002c);
    prog[28] = enc_i(SW, 3, 0, 16'h0030);
    prog[29] = enc_i(SW, 4, 0, 16'h0034);
    prog[30] = {J, 26'd33};
    prog[31] = enc_i(SW, 1, 0, 16'h0038);
    prog[32] = enc_i(SW, 2, 0, 16'h003c);
    prog[33] = enc_i(SW, 2, 0, 16'h0040);
    prog[34] = {HALT, 26'd0};
    prog[35] = enc_i(SW, 1, 0, 16'h0044);
    exp_addr = '{32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14,
                 32'h18, 32'h1c, 32'h20, 32'h24, 32'h34, 32'h40};
    exp_data = '{32'h2, 32'h8, 32'hfd, 32'hf5, 32'h1, 32'h1234_5678,
                 32'h0, 32'hc0de_1015, 32'h1234_5678, 32'h5, 32'h8, 32'hffff_fffd};
    exp_load = '{32'h40, 32'h14};
  endtask

  // fetch and data responders, wait count drawn once per new request
  always @(posedge clk) begin
    #5;
    if (!imem_ren) begin
      ihit      = 1'b0;
      i_pending = 1'b0;
    end else begin
      if (!i_pending || (imem_addr != i_addr_q)) begin
        i_pending = 1'b1;
        i_addr_q  = imem_addr;
        i_left    = take_bits(2);
      end
      ihit      = (i_left == 0);
      imem_load = ihit ? imem[imem_addr[9:2]] : '0;
      i_pending = !ihit;
      i_left    = ihit ? 0 : i_left - 1;
    end
    if (!(dmem_ren || dmem_wen)) begin
      dhit      = 1'b0;
      d_pending = 1'b0;
    end else begin
      if (!d_pending || (dmem_addr != d_addr_q)) begin
        d_pending = 1'b1;
        d_addr_q  = dmem_addr;
        d_left    = take_bits(2);
      end
      dhit      = (d_left == 0);
      dmem_load = (dhit && dmem_ren) ? dmem[dmem_addr[9:2]] : '0;
      d_pending = !dhit;
      d_left    = dhit ? 0 : d_left - 1;
    end
  end

  // completed loads, addresses in program order
  always @(negedge clk) begin
    if (arst_n && dmem_ren && dhit) begin
      if (loads_seen < NUM_LOADS) begin
        assert (dmem_addr == exp_load[loads_seen]) else begin
          $display("[FAIL] dmem_addr: expected load from 0x%08h, got 0x%08h",
                   exp_load[loads_seen], dmem_addr);
          errors++;
        end
      end else begin
        $display("unexpected extra load from 0x%08h", dmem_addr);
        errors++;
      end
      loads_seen++;
    end
  end

  // completed stores, compared in program order
  always @(negedge clk) begin
    if (arst_n && dmem_wen && dhit) begin
      dmem[dmem_addr[9:2]] = dmem_store;
      assert (!halt) else begin
        $display("store to 0x%08h after halt", dmem_addr);
        errors++;
      end
      if (stores_seen < NUM_STORES) begin
        assert (dmem_addr == exp_addr[stores_seen]) else begin
          $display("[FAIL] dmem_addr: expected 0x%08h, got 0x%08h",
                   exp_addr[stores_seen], dmem_addr);
          errors++;
        end
        assert (dmem_store == exp_data[stores_seen]) else begin
          $display("[FAIL] dmem_store: expected 0x%08h, got 0x%08h",
                   exp_data[stores_seen], dmem_store);
          errors++;
        end
      end else begin
        $display("unexpected extra store to 0x%08h", dmem_addr);
        errors++;
      end
      stores_seen++;
    end
  end

  initial begin
    int cycles;
    ihit      = 1'b0;
    dhit      = 1'b0;
    imem_load = '0;
    dmem_load = '0;
    load_tables();
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < PROG_LEN) ? prog[i] : '0;
      dmem[i] = fill_word(i);
    end
    cycles = 0;
    while (!arst_n && (cycles < 20)) begin
      @(negedge clk);
      cycles++;
    end
    assert (arst_n) else begin
      $display("reset never released");
      errors++;
    end
    cycles = 0;
    while (!halt && (cycles < 3000)) begin
      @(negedge clk);
      cycles++;
    end
    assert (halt) else begin
      $display("halt did not rise within %0d cycles", cycles);
      errors++;
    end
    assert (stores_seen == NUM_STORES) else begin
      $display("saw %0d stores before halt instead of %0d", stores_seen, NUM_STORES);
      errors++;
    end
    assert (loads_seen == NUM_LOADS) else begin
      $display("saw %0d loads before halt instead of %0d", loads_seen, NUM_LOADS);
      errors++;
    end
    // fetch must stay off once halted
    repeat (20) begin
      @(negedge clk);
      assert (!imem_ren) else begin
        $display("[FAIL] imem_ren: expected 0x0, got 0x%0h after halt", imem_ren);
        errors++;
      end
    end
    $display("errors: %0d, stores seen: %0d of %0d, loads seen: %0d of %0d",
             errors, stores_seen, NUM_STORES, loads_seen, NUM_LOADS);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/datapath_asserts.sv
/* memory-port and halt rules of the pipeline top level, bound to datapath */
`timescale 1ns/1ns
`default_nettype none

module datapath_asserts
  import cpu_types_pkg::*;
(
  input wire logic  CLK,
  input wire logic  arst_n,
  input wire logic  imem_ren,
  input wire word_t imem_addr,
  input wire logic  ihit,
  input wire logic  dmem_ren,
  input wire logic  dmem_wen,
  input wire word_t dmem_addr,
  input wire logic  dhit,
  input wire logic  halt
);

  // an open fetch keeps its address until ihit, unless halt withdraws it
  a_fetch_hold: assert property (@(posedge CLK) disable iff (!arst_n)
    (imem_ren && !ihit) |=> (halt || (imem_ren && $stable(imem_addr))))
    else $error("fetch request changed before ihit");

  a_data_hold: assert property (@(posedge CLK) disable iff (!arst_n)
    ((dmem_ren || dmem_wen) && !dhit) |=>
      ($stable(dmem_addr) && $stable(dmem_ren) && $stable(dmem_wen)))
    else $error("data request changed before dhit");

  a_one_access: assert property (@(posedge CLK) disable iff (!arst_n)
    !(dmem_ren && dmem_wen))
    else $error("dmem_ren and dmem_wen high together");

  // sticky until the next reset
  a_halt_sticky: assert property (@(posedge CLK) disable iff (!arst_n)
    halt |=> halt)
    else $error("halt fell without reset");

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
/* 40 ns clock; reset held low for five rising edges, released 5 ns after the fifth */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic arst_n
);

  initial begin
    CLK    = 1'b0;
    arst_n = 1'b0;
  end

  always #20 CLK = ~CLK;

  initial begin
    repeat (5) @(posedge CLK);
    #5 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- source/datapath.sv
/* five-stage pipeline; a request holds until ihit/dhit, BEQ resolves in MEM and
   squashes three younger instructions, J resolves in ID; halt stays high until reset */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module datapath
  import cpu_types_pkg::*;
(
  input  logic  CLK,
  input  logic  arst_n,
  output logic  imem_ren,
  output word_t imem_addr,
  input  word_t imem_load,
  input  logic  ihit,
  output logic  dmem_ren,
  output logic  dmem_wen,
  output word_t dmem_addr,
  output word_t dmem_store,
  input  word_t dmem_load,
  input  logic  dhit,
  output logic  halt
);
  // fetch
  word_t    pc, pc_plus4, pc_next;
  logic     running, ihit_eff, halting;
  // decode
  word_t    if_id_instr, if_id_npc, imm_ext, jump_target, rdat1, rdat2;
  opcode_t  opcode_id;
  funct_t   func_id;
  regbits_t rs_id, rt_id, rd_id;
  aluop_t   ctl_alu_op;
  alusrc_t  ctl_alu_src;
  regdst_t  ctl_reg_dst;
  wbsel_t   ctl_wb_sel;
  extend_t  ctl_extend;
  logic     ctl_reg_wen, ctl_dren, ctl_dwen, ctl_branch, ctl_jump, ctl_halt;
  // execute
  aluop_t   id_ex_alu_op;
  alusrc_t  id_ex_alu_src;
  regdst_t  id_ex_reg_dst;
  wbsel_t   id_ex_wb_sel;
  logic     id_ex_reg_wen, id_ex_dren, id_ex_dwen, id_ex_branch, id_ex_halt;
  regbits_t id_ex_rs, id_ex_rt, id_ex_rd, dest_ex;
  word_t    id_ex_rdat1, id_ex_rdat2, id_ex_imm, id_ex_npc;
  word_t    alu_a, alu_b, rt_fwd, store_fwd, alu_result, branch_target;
  logic     alu_zero;
  fwd_sel_t fwd_a, fwd_b, fwd_store;
  // memory
  wbsel_t   ex_mem_wb_sel;
  logic     ex_mem_reg_wen, ex_mem_dren, ex_mem_dwen, ex_mem_branch, ex_mem_halt;
  logic     ex_mem_zero, take_branch;
  regbits_t ex_mem_dest;
  word_t    ex_mem_result, ex_mem_store, ex_mem_target;
  // writeback
  wbsel_t   mem_wb_wb_sel;
  logic     mem_wb_reg_wen, mem_wb_halt;
  regbits_t mem_wb_dest;
  word_t    mem_wb_result, mem_wb_load, wdat;
  // stage control
  logic     pc_en, if_id_en, id_ex_en, ex_mem_en, mem_wb_en;
  logic     if_id_flush, id_ex_flush, ex_mem_flush;

  function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                    word_t wb_val);
    word_t val;
    case (sel)
      FWD_MEM: val = mem_val;
      FWD_WB:  val = wb_val;
      default: val = reg_val;
    endcase
    return val;
  endfunction

  register_file u_regs (
    .CLK(CLK), .arst_n(arst_n), .wen(mem_wb_reg_wen), .wsel(mem_wb_dest), .wdat(wdat),
    .rsel1(rs_id), .rsel2(rt_id), .rdat1(rdat1), .rdat2(rdat2)
  );

  control_unit u_ctrl (
    .opcode(opcode_id), .func(func_id), .alu_op(ctl_alu_op), .alu_src(ctl_alu_src),
    .reg_dst(ctl_reg_dst), .wb_sel(ctl_wb_sel), .extend(ctl_extend), .reg_wen(ctl_reg_wen),
    .dmem_ren_req(ctl_dren), .dmem_wen_req(ctl_dwen), .branch(ctl_branch),
    .jump(ctl_jump), .halt_req(ctl_halt)
  );

  hazard_unit u_hazard (
    .ihit(ihit_eff), .dhit(dhit), .dmem_busy(ex_mem_dren || ex_mem_dwen),
    .load_ex(id_ex_dren), .rt_ex(id_ex_rt), .rs_id(rs_id), .rt_id(rt_id),
    .jump_id(ctl_jump), .take_branch(take_branch), .halted(halting),
    .pc_en(pc_en), .if_id_en(if_id_en), .id_ex_en(id_ex_en), .ex_mem_en(ex_mem_en),
    .mem_wb_en(mem_wb_en), .if_id_flush(if_id_flush), .id_ex_flush(id_ex_flush),
    .ex_mem_flush(ex_mem_flush)
  );

  forward_unit u_fwd (
    .rs_ex(id_ex_rs), .rt_ex(id_ex_rt), .dest_mem(ex_mem_dest), .wen_mem(ex_mem_reg_wen),
    .load_mem(ex_mem_dren), .dest_wb(mem_wb_dest), .wen_wb(mem_wb_reg_wen),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_store(fwd_store)
  );

  alu u_alu (
    .alu_op(id_ex_alu_op), .port_a(alu_a), .port_b(alu_b), .result(alu_result),
    .zero(alu_zero)
  );

  // fetch, nothing is requested before the first cycle out of reset
  assign imem_ren  = running && !halt;
  assign imem_addr = pc;
  assign ihit_eff  = ihit || !imem_ren;
  assign halting   = !running || ctl_halt || id_ex_halt || ex_mem_halt || mem_wb_halt || halt;
  assign pc_plus4  = pc + 32'd4;
  assign pc_next   = take_branch ? ex_mem_target : (ctl_jump ? jump_target : pc_plus4);

  always_ff @(posedge CLK, negedge arst_n) begin
    if (!arst_n) begin
      pc      <= `PC_INIT;
      running <= 1'b0;
      halt    <= 1'b0;
    end else begin
      running <= 1'b1;
      if (pc_en) begin
        pc <= pc_next;
      end
      if (mem_wb_halt) begin
        halt <= 1'b1;
      end
    end
  end

  // IF/ID, a zero word decodes as a no-op
  always_ff @(posedge CLK, negedge arst_n) begin
    if (!arst_n) begin
      if_id_instr <= '0;
    end else if (if_id_en) begin
      if_id_instr <= if_id_flush ? '0 : imem_load;
    end
  end

  always_ff @(posedge CLK) begin
    if (if_id_en) begin
      if_id_npc <= pc_plus4;
    end
  end

  // decode
  assign opcode_id   = opcode_t'(if_id_instr[31:26]);
  assign func_id     = funct_t'(if_id_instr[5:0]);
  assign rs_id       = if_id_instr[25:21];
  assign rt_id       = if_id_instr[20:16];
  assign rd_id       = if_id_instr[15:11];
  assign jump_target = {if_id_npc[31:28], if_id_instr[25:0], 2'b00};

  // lui shifts in the ALU, so only sign and zero extension are needed here
  always_comb begin
    case (ctl_extend)
      EXT_SIGN: imm_ext = {{16{if_id_instr[15]}}, if_id_instr[15:0]};
      default:  imm_ext = {16'h0000, if_id_instr[15:0]};
    endcase
  end

  // ID/EX
  always_ff @(posedge CLK, negedge arst_n) begin
    if (!arst_n) begin
      {id_ex_reg_wen, id_ex_dren, id_ex_dwen, id_ex_branch, id_ex_halt} <= 5'b0;
    end else if (id_ex_en) begin
      {id_ex_reg_wen, id_ex_dren, id_ex_dwen, id_ex_branch, id_ex_halt} <=
        id_ex_flush ? 5'b0 : {ctl_reg_wen, ctl_dren, ctl_dwen, ctl_branch, ctl_halt};
    end
  end

  always_ff @(posedge CLK) begin
    if (id_ex_en) begin
      id_ex_alu_op  <= ctl_alu_op;
      id_ex_alu_src <= ctl_alu_src;
      id_ex_reg_dst <= ctl_reg_dst;
      id_ex_wb_sel  <= ctl_wb_sel;
      id_ex_rs      <= rs_id;
      id_ex_rt      <= rt_id;
      id_ex_rd      <= rd_id;
      id_ex_rdat1   <= rdat1;
      id_ex_rdat2   <= rdat2;
      id_ex_imm     <= imm_ext;
      id_ex_npc     <= if_id_npc;
    end
  end

  // execute
  assign alu_a         = fwd_mux(fwd_a, id_ex_rdat1, ex_mem_result, wdat);
  assign rt_fwd        = fwd_mux(fwd_b, id_ex_rdat2, ex_mem_result, wdat);
  assign store_fwd     = fwd_mux(fwd_store, id_ex_rdat2, ex_mem_result, wdat);
  assign alu_b         = (id_ex_alu_src == SRC_IMM) ? id_ex_imm : rt_fwd;
  assign dest_ex       = (id_ex_reg_dst == DST_RD) ? id_ex_rd : id_ex_rt;
  assign branch_target = id_ex_npc + {id_ex_imm[29:0], 2'b00};

  // EX/MEM
  always_ff @(posedge CLK, negedge arst_n) begin
    if (!arst_n) begin
      {ex_mem_reg_wen, ex_mem_dren, ex_mem_dwen, ex_mem_branch, ex_mem_halt} <= 5'b0;
    end else if (ex_mem_en) begin
      {ex_mem_reg_wen, ex_mem_dren, ex_mem_dwen, ex_mem_branch, ex_mem_halt} <=
        ex_mem_flush ? 5'b0 : {id_ex_reg_wen, id_ex_dren, id_ex_dwen, id_ex_branch, id_ex_halt};
    end
  end

  always_ff @(posedge CLK) begin
    if (ex_mem_en) begin
      ex_mem_wb_sel <= id_ex_wb_sel;
      ex_mem_dest   <= dest_ex;
      ex_mem_result <= alu_result;
      ex_mem_zero   <= alu_zero;
      ex_mem_store  <= store_fwd;
      ex_mem_target <= branch_target;
    end
  end

  // memory, request comes straight from EX/MEM so it holds while frozen
  assign dmem_ren    = ex_mem_dren;
  assign dmem_wen    = ex_mem_dwen;
  assign dmem_addr   = ex_mem_result;
  assign dmem_store  = ex_mem_store;
  assign take_branch = ex_mem_branch && ex_mem_zero;

  // MEM/WB
  always_ff @(posedge CLK, negedge arst_n) begin
    if (!arst_n) begin
      {mem_wb_reg_wen, mem_wb_halt} <= 2'b0;
    end else if (mem_wb_en) begin
      {mem_wb_reg_wen, mem_wb_halt} <= {ex_mem_reg_wen, ex_mem_halt};
    end
  end

  always_ff @(posedge CLK) begin
    if (mem_wb_en) begin
      mem_wb_wb_sel <= ex_mem_wb_sel;
      mem_wb_dest   <= ex_mem_dest;
      mem_wb_result <= ex_mem_result;
      mem_wb_load   <= dmem_load;
    end
  end

  assign wdat = (mem_wb_wb_sel == WB_LOAD) ? mem_wb_load : mem_wb_result;

endmodule

`default_nettype wire

//--- source/forward_unit.sv
/* operand source selection for EX; a load still in EX/MEM is never a source,
   the hazard unit stalls that case */
`timescale 1ns/1ns
`default_nettype none

module forward_unit
  import cpu_types_pkg::*;
(
  input  regbits_t rs_ex,
  input  regbits_t rt_ex,
  input  regbits_t dest_mem,
  input  logic     wen_mem,
  input  logic     load_mem,
  input  regbits_t dest_wb,
  input  logic     wen_wb,
  output fwd_sel_t fwd_a,
  output fwd_sel_t fwd_b,
  output fwd_sel_t fwd_store
);
  logic mem_ok;
  logic wb_ok;

  // youngest producer first
  function automatic fwd_sel_t pick(regbits_t src, regbits_t dm, logic mok,
                                    regbits_t dw, logic wok);
    fwd_sel_t sel;
    sel = FWD_REG;
    if (mok && (dm == src)) begin
      sel = FWD_MEM;
    end else if (wok && (dw == src)) begin
      sel = FWD_WB;
    end
    return sel;
  endfunction

  assign mem_ok = wen_mem && !load_mem && (dest_mem != '0);
  assign wb_ok  = wen_wb && (dest_wb != '0);

  assign fwd_a     = pick(rs_ex, dest_mem, mem_ok, dest_wb, wb_ok);
  assign fwd_b     = pick(rt_ex, dest_mem, mem_ok, dest_wb, wb_ok);
  assign fwd_store = pick(rt_ex, dest_mem, mem_ok, dest_wb, wb_ok);

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
/* stage enables and flushes, highest priority first: data wait, branch, jump, halt drain,
   load-use stall, fetch wait; ihit must read high when no fetch is outstanding */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit
  import cpu_types_pkg::*;
(
  input  logic     ihit,
  input  logic     dhit,
  input  logic     dmem_busy,
  input  logic     load_ex,
  input  regbits_t rt_ex,
  input  regbits_t rs_id,
  input  regbits_t rt_id,
  input  logic     jump_id,
  input  logic     take_branch,
  input  logic     halted,
  output logic     pc_en,
  output logic     if_id_en,
  output logic     id_ex_en,
  output logic     ex_mem_en,
  output logic     mem_wb_en,
  output logic     if_id_flush,
  output logic     id_ex_flush,
  output logic     ex_mem_flush
);
  logic mem_wait;
  logic fetch_wait;
  logic load_use;

  assign mem_wait   = dmem_busy && !dhit;
  assign fetch_wait = !ihit;
  assign load_use   = load_ex && (rt_ex != '0) && ((rt_ex == rs_id) || (rt_ex == rt_id));

  always_comb begin
    {pc_en, if_id_en, id_ex_en, ex_mem_en, mem_wb_en} = 5'b11111;
    {if_id_flush, id_ex_flush, ex_mem_flush} = 3'b000;
    if (mem_wait || (take_branch && fetch_wait)) begin
      // whole pipe holds, a redirect waits until the open fetch completes
      {pc_en, if_id_en, id_ex_en, ex_mem_en, mem_wb_en} = 5'b00000;
    end else if (take_branch) begin
      {if_id_flush, id_ex_flush, ex_mem_flush} = 3'b111;
    end else if ((jump_id && fetch_wait) || (!jump_id && !halted && load_use)) begin
      // keep ID, bubble into EX
      pc_en       = 1'b0;
      if_id_en    = 1'b0;
      id_ex_flush = 1'b1;
    end else if (jump_id) begin
      if_id_flush = 1'b1;
    end else if (halted || fetch_wait) begin
      // no new instruction enters decode
      pc_en       = 1'b0;
      if_id_flush = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/control_unit.sv
/* main decoder; any unsupported opcode or funct decodes as a no-op with no writes */
`timescale 1ns/1ns
`default_nettype none

module control_unit
  import cpu_types_pkg::*;
(
  input  opcode_t opcode,
  input  funct_t  func,
  output aluop_t  alu_op,
  output alusrc_t alu_src,
  output regdst_t reg_dst,
  output wbsel_t  wb_sel,
  output extend_t extend,
  output logic    reg_wen,
  output logic    dmem_ren_req,
  output logic    dmem_wen_req,
  output logic    branch,
  output logic    jump,
  output logic    halt_req
);

  always_comb begin
    alu_op       = ALU_ADD;
    alu_src      = SRC_REG;
    reg_dst      = DST_RT;
    wb_sel       = WB_ALU;
    extend       = EXT_SIGN;
    reg_wen      = 1'b0;
    dmem_ren_req = 1'b0;
    dmem_wen_req = 1'b0;
    branch       = 1'b0;
    jump         = 1'b0;
    halt_req     = 1'b0;
    case (opcode)
      RTYPE: begin
        reg_dst = DST_RD;
        reg_wen = 1'b1;
        case (func)
          ADDU:    alu_op = ALU_ADD;
          SUBU:    alu_op = ALU_SUB;
          AND:     alu_op = ALU_AND;
          OR:      alu_op = ALU_OR;
          SLT:     alu_op = ALU_SLT;
          // includes the all-zero bubble word
          default: reg_wen = 1'b0;
        endcase
      end
      ADDIU: begin
        alu_src = SRC_IMM;
        reg_wen = 1'b1;
      end
      ORI: begin
        alu_op  = ALU_OR;
        alu_src = SRC_IMM;
        extend  = EXT_ZERO;
        reg_wen = 1'b1;
      end
      LUI: begin
        alu_op  = ALU_LUI;
        alu_src = SRC_IMM;
        extend  = EXT_ZERO;
        reg_wen = 1'b1;
      end
      LW: begin
        alu_src      = SRC_IMM;
        wb_sel       = WB_LOAD;
        reg_wen      = 1'b1;
        dmem_ren_req = 1'b1;
      end
      SW: begin
        alu_src      = SRC_IMM;
        dmem_wen_req = 1'b1;
      end
      // equality test through subtract, target built from the sign-extended offset
      BEQ: begin
        alu_op = ALU_SUB;
        branch = 1'b1;
      end
      J:       jump = 1'b1;
      HALT:    halt_req = 1'b1;
      default: reg_wen = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/alu.sv
/* combinational ALU; slt compares as signed, lui takes the low half of port_b */
`timescale 1ns/1ns
`default_nettype none

module alu
  import cpu_types_pkg::*;
(
  input  aluop_t alu_op,
  input  word_t  port_a,
  input  word_t  port_b,
  output word_t  result,
  output logic   zero
);

  always_comb begin
    case (alu_op)
      ALU_ADD: result = port_a + port_b;
      ALU_SUB: result = port_a - port_b;
      ALU_AND: result = port_a & port_b;
      ALU_OR:  result = port_a | port_b;
      ALU_SLT: begin
        result = '0;
        if ($signed(port_a) < $signed(port_b)) begin
          result[0] = 1'b1;
        end
      end
      // immediate arrives zero extended, move it to the upper half
      ALU_LUI: result = {port_b[15:0], 16'h0000};
      default: result = port_a + port_b;
    endcase
  end

  // beq subtracts, equal operands give zero
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- source/register_file.sv
/* 32 x 32 register file, r0 reads as zero
   a read of the register written this cycle returns the new value */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module register_file
  import cpu_types_pkg::*;
(
  input  logic     CLK,
  input  logic     arst_n,
  input  logic     wen,
  input  regbits_t wsel,
  input  word_t    wdat,
  input  regbits_t rsel1,
  input  regbits_t rsel2,
  output word_t    rdat1,
  output word_t    rdat2
);
  word_t regs [2**`REG_W];
  logic  wr_live;

  assign wr_live = wen && (wsel != '0);

  always_ff @(posedge CLK, negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**`REG_W; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wsel] <= wdat;
    end
  end

  // bypass so decode sees the writeback of the same cycle
  assign rdat1 = (wr_live && (wsel == rsel1)) ? wdat : regs[rsel1];
  assign rdat2 = (wr_live && (wsel == rsel2)) ? wdat : regs[rsel2];

endmodule

`default_nettype wire

//--- source/cpu_types_pkg.sv
/* pipeline types; opcode and funct values follow MIPS-I encodings */
`default_nettype none
`include "cpu_consts.svh"

package cpu_types_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`REG_W-1:0]  regbits_t;

  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = `HALT_OP
  } opcode_t;

  // only the R-type functions the core executes
  typedef enum logic [5:0] {
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } aluop_t;

  // mux selects
  typedef enum logic {SRC_REG, SRC_IMM} alusrc_t;
  typedef enum logic {DST_RD, DST_RT} regdst_t;
  typedef enum logic {WB_ALU, WB_LOAD} wbsel_t;
  typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} extend_t;
  typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_t;

endpackage

`default_nettype wire

//--- source/cpu_consts.svh
/* widths and fixed encodings for the pipeline sources
   the halt opcode must not collide with any supported MIPS opcode */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data and address width
`define WORD_W 32

// register index width, 32 registers
`define REG_W 5

// first fetch address after reset
`define PC_INIT 32'h0000_0000

// link register for JAL, which this core does not implement
`define RET_REG 5'd31

`define HALT_OP 6'b111111

`endif
